// ==== verilog.f ====
+incdir+src
src/proc_types_pkg.sv
src/ucode_pkg.sv
src/alu.sv
src/processor.sv
src/microcode_store.sv
src/micro_counter.sv
src/control_sequencer.sv
src/micro_cpu_top.sv
testbench/tb_micro_cpu.sv

// ==== testbench/tb_micro_cpu.sv ====
// Testbench for the microcoded processor

`timescale 1ns/1ps
`include "proc_defines.svh"

module tb_micro_cpu
    import proc_types_pkg::*;
    import ucode_pkg::*;
;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int MAX_WAIT        = 12;
    localparam int N_RANDOM        = 300;
    // Corner cases, single-word, multi-word, start-while-busy and random runs
    localparam int N_OPS           = 4 + 56 + 16 + 16 + N_RANDOM;
    localparam int WATCHDOG_CYCLES = N_OPS * 10 + RESET_CYCLES;

    logic              system_clk;
    logic              arst_n;
    data_t             data_in_a;
    data_t             data_in_b;
    logic [`OPC_W-1:0] opcode;
    logic              start;
    data_t             data_out;
    status_t           status_bits;
    logic              busy;
    logic              done;

    micro_cpu_top dut (
        .system_clk  (system_clk),
        .arst_n      (arst_n),
        .data_in_a   (data_in_a),
        .data_in_b   (data_in_b),
        .opcode      (opcode),
        .start       (start),
        .data_out    (data_out),
        .status_bits (status_bits),
        .busy        (busy),
        .done        (done)
    );

    initial begin
        system_clk = 1'b0;
        forever #(CLK_PERIOD / 2) system_clk = ~system_clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge system_clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s actual=0x%0h expected=0x%0h",
                     $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // Returns {c4, c8, sum} of x + y + c
    function automatic logic [9:0] add_with_carries(input data_t x, input data_t y,
                                                    input logic c);
        logic [8:0] s9;
        logic [4:0] s5;
        s9 = {1'b0, x} + {1'b0, y} + {8'd0, c};
        s5 = {1'b0, x[3:0]} + {1'b0, y[3:0]} + {4'd0, c};
        return {s5[4], s9};
    endfunction

    task automatic predict_result(input logic [`OPC_W-1:0] opc, input data_t a,
                                  input data_t b, output data_t f, output status_t st);
        logic [9:0] r;
        data_t      ta;
        data_t      tb;
        r = '0;
        case (opc)
            OP_ADD:  r = add_with_carries(a, b, 1'b0);
            OP_SUB:  r = add_with_carries(a, ~b, 1'b1);
            OP_AND:  r = {2'b00, a & b};
            OP_OR:   r = {2'b00, a | b};
            OP_XOR:  r = {2'b00, a ^ b};
            OP_INC:  r = add_with_carries(a, 8'h00, 1'b1);
            OP_DSUM: begin
                ta = a + b;
                r  = add_with_carries(ta, ta, 1'b0);
            end
            OP_SUMSUB: begin
                ta = a + b;
                tb = a - b;
                r  = {2'b00, ta ^ tb};
            end
            // Any code from 8 up moves A to F
            default: r = {2'b00, a};
        endcase
        f         = r[7:0];
        st[ST_C4] = r[9];
        st[ST_C8] = r[8];
        st[ST_Z]  = (f == 8'h00);
        st[ST_N]  = f[7];
    endtask

    // Two cycles of overhead plus one per microword
    function automatic int expected_latency(input logic [`OPC_W-1:0] opc);
        if (opc == OP_DSUM) begin
            return 4;
        end else if (opc == OP_SUMSUB) begin
            return 5;
        end
        return 3;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge system_clk);
            start <= 1'b0;
            @(negedge system_clk);
            check_value("busy", busy, 1'b0);
            check_value("done", done, 1'b0);
        end
    endtask

    // Runs one operation; extra_at > 0 pulses start again in that busy cycle
    task automatic run_op(input logic [`OPC_W-1:0] opc, input data_t a, input data_t b,
                          input int extra_at);
        data_t   exp_f;
        status_t exp_st;
        int      cycles;
        logic    seen_done;
        predict_result(opc, a, b, exp_f, exp_st);
        cycles    = 0;
        seen_done = 1'b0;
        @(posedge system_clk);
        start     <= 1'b1;
        opcode    <= opc;
        data_in_a <= a;
        data_in_b <= b;
        @(negedge system_clk);
        check_value("busy", busy, 1'b0);
        check_value("done", done, 1'b0);
        while (!seen_done) begin
            @(posedge system_clk);
            cycles++;
            if (cycles == extra_at) begin
                // Operands are already latched, so new inputs must not matter
                start     <= 1'b1;
                opcode    <= $urandom % 16;
                data_in_a <= $urandom % 256;
                data_in_b <= $urandom % 256;
            end else begin
                start <= 1'b0;
            end
            @(negedge system_clk);
            check_value("busy", busy, 1'b1);
            if (done) begin
                seen_done = 1'b1;
            end else if (cycles >= MAX_WAIT) begin
                $display("Timeout: done did not arrive within %0d cycles of start", MAX_WAIT);
                $display("TEST RESULT: FAIL");
                $fatal(1, "operation timed out");
            end
        end
        check_value("latency", cycles, expected_latency(opc));
        check_value("data_out", data_out, exp_f);
        check_value("status_bits", status_bits, exp_st);
    endtask

    initial begin
        int                lat;
        logic [`OPC_W-1:0] opc;
        void'($urandom(32'h89fe));
        arst_n    = 1'b0;
        start     = 1'b0;
        opcode    = '0;
        data_in_a = '0;
        data_in_b = '0;
        repeat (RESET_CYCLES) @(posedge system_clk);
        arst_n <= 1'b1;

        // Quiet outputs after reset
        idle_cycles(2);
        check_value("data_out", data_out, 8'h00);
        check_value("status_bits", status_bits, 4'h0);

        // Carry and zero corners
        run_op(OP_ADD, 8'hff, 8'h01, 0);
        run_op(OP_SUB, 8'h5a, 8'h5a, 0);
        run_op(OP_INC, 8'hff, 8'h00, 0);
        run_op(OP_XOR, 8'h3c, 8'h3c, 0);

        // Single-word opcodes, moves from the whole upper range
        for (int rep = 0; rep < 8; rep++) begin
            for (int k = 0; k < 7; k++) begin
                opc = (k < 6) ? k : 8 + ($urandom % 8);
                run_op(opc, $urandom % 256, $urandom % 256, 0);
                idle_cycles($urandom % 2);
            end
        end

        // Temp registers and source muxes
        for (int rep = 0; rep < 8; rep++) begin
            run_op(OP_DSUM, $urandom % 256, $urandom % 256, 0);
            run_op(OP_SUMSUB, $urandom % 256, $urandom % 256, 0);
        end

        // Second start while busy
        for (int rep = 0; rep < 16; rep++) begin
            opc = $urandom % 16;
            lat = expected_latency(opc);
            run_op(opc, $urandom % 256, $urandom % 256, 2 + ($urandom % (lat - 2)));
        end

        // Long random run with gaps
        for (int n = 0; n < N_RANDOM; n++) begin
            idle_cycles($urandom % 4);
            run_op($urandom % 16, $urandom % 256, $urandom % 256, 0);
        end

        idle_cycles(2);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== src/micro_cpu_top.sv ====
// Microcoded processor top

`timescale 1ns/1ps
`include "proc_defines.svh"

module micro_cpu_top
    import proc_types_pkg::*;
    import ucode_pkg::*;
(
    input  logic              system_clk,
    input  logic              arst_n,
    input  data_t             data_in_a,
    input  data_t             data_in_b,
    input  logic [`OPC_W-1:0] opcode,
    input  logic              start,
    output data_t             data_out,
    output status_t           status_bits,
    output logic              busy,
    output logic              done
);

    logic       eil;
    logic       load;
    logic       step;
    uaddr_t     uaddr;
    ctrl_word_t ctrl_word;
    ctrl_word_t gated_ctrl;

    control_sequencer u_seq (
        .system_clk (system_clk),
        .arst_n     (arst_n),
        .start      (start),
        .ctrl_word  (ctrl_word),
        .eil        (eil),
        .load       (load),
        .step       (step),
        .gated_ctrl (gated_ctrl),
        .busy       (busy),
        .done       (done)
    );

    micro_counter u_upc (
        .system_clk (system_clk),
        .arst_n     (arst_n),
        .load       (load),
        .step       (step),
        .opcode     (opcode),
        .uaddr      (uaddr)
    );

    microcode_store u_store (
        .uaddr     (uaddr),
        .ctrl_word (ctrl_word)
    );

    processor u_proc (
        .system_clk   (system_clk),
        .arst_n       (arst_n),
        .data_in_a    (data_in_a),
        .data_in_b    (data_in_b),
        .eil          (eil),
        .control_bits (gated_ctrl),
        .data_out     (data_out),
        .status_bits  (status_bits)
    );

endmodule

// ==== src/control_sequencer.sv ====
// Control sequencer

`timescale 1ns/1ps

module control_sequencer
    import ucode_pkg::*;
(
    input  logic       system_clk,
    input  logic       arst_n,
    input  logic       start,
    input  ctrl_word_t ctrl_word,
    output logic       eil,
    output logic       load,
    output logic       step,
    output ctrl_word_t gated_ctrl,
    output logic       busy,
    output logic       done
);

    seq_state_e state, state_nxt;
    logic       exec_en;

    always_ff @(posedge system_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            // Start outside IDLE has no effect
            IDLE: if (start) state_nxt = LOAD;
            LOAD: state_nxt = EXEC;
            EXEC: if (ctrl_word[CW_LAST]) state_nxt = DONE;
            DONE: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // Operand load and counter preset share the LOAD cycle
    assign eil     = (state == LOAD);
    assign load    = (state == LOAD);
    assign exec_en = (state == EXEC);
    assign step    = exec_en;

    // Datapath sees a zero word outside EXEC
    assign gated_ctrl = exec_en ? ctrl_word : '0;

    assign busy = (state != IDLE);
    assign done = (state == DONE);

    // Final microword writes F, so result and flags are valid with done
    a_last_writes_f: assert property (
        @(posedge system_clk) disable iff (!arst_n)
        (exec_en && ctrl_word[CW_LAST]) |-> ctrl_word[CW_DEST_MSB]
    );

endmodule

// ==== src/micro_counter.sv ====
// Microprogram address counter

`timescale 1ns/1ps
`include "proc_defines.svh"

module micro_counter
    import ucode_pkg::*;
(
    input  logic              system_clk,
    input  logic              arst_n,
    input  logic              load,
    input  logic              step,
    input  logic [`OPC_W-1:0] opcode,
    output uaddr_t            uaddr
);

    localparam int LAST_OFS = `UWORDS_PER_OP - 1;

    uaddr_t base;

    // Start of the opcode's block
    assign base = uaddr_t'(opcode) * uaddr_t'(`UWORDS_PER_OP);

    always_ff @(posedge system_clk or negedge arst_n) begin
        if (!arst_n) begin
            uaddr <= '0;
        end else if (load) begin
            uaddr <= base;
        end else if (step) begin
            uaddr <= uaddr + 1'b1;
        end
    end

    // Every microprogram ends inside its own block
    a_step_in_block: assert property (
        @(posedge system_clk) disable iff (!arst_n)
        (step && !load) |-> ((uaddr % `UWORDS_PER_OP) != LAST_OFS)
    );

endmodule

// ==== src/microcode_store.sv ====
// Microprogram store

`timescale 1ns/1ps
`include "proc_defines.svh"

module microcode_store
    import ucode_pkg::*;
(
    input  uaddr_t     uaddr,
    output ctrl_word_t ctrl_word
);

    localparam int OFS_W = $clog2(`UWORDS_PER_OP);

    logic [`OPC_W-1:0] blk;
    logic [OFS_W-1:0]  ofs;

    // Build one control word from its fields
    function automatic ctrl_word_t cw(
        input logic      a_src,
        input logic      b_src,
        input alu_func_e func,
        input logic      c_in,
        input alu_dest_t dest,
        input logic      last
    );
        ctrl_word_t w;
        w                           = '0;
        w[CW_A_SRC]                 = a_src;
        w[CW_B_SRC]                 = b_src;
        w[CW_FUNC_MSB:CW_FUNC_LSB]  = func;
        w[CW_CIN]                   = c_in;
        w[CW_DEST_MSB:CW_DEST_LSB]  = dest;
        w[CW_LAST]                  = last;
        return w;
    endfunction

    assign blk = uaddr[`UADDR_W-1:OFS_W];
    assign ofs = uaddr[OFS_W-1:0];

    always_comb begin
        // Unlisted addresses and moves: F gets A, then stop
        ctrl_word = cw(1'b0, 1'b0, ALU_PASS_A, 1'b0, DEST_F, 1'b1);
        case (opcode_e'(blk))
            OP_ADD: if (ofs == 0) ctrl_word = cw(1'b0, 1'b0, ALU_ADD, 1'b0, DEST_F, 1'b1);
            OP_SUB: if (ofs == 0) ctrl_word = cw(1'b0, 1'b0, ALU_SUB, 1'b1, DEST_F, 1'b1);
            OP_AND: if (ofs == 0) ctrl_word = cw(1'b0, 1'b0, ALU_AND, 1'b0, DEST_F, 1'b1);
            OP_OR:  if (ofs == 0) ctrl_word = cw(1'b0, 1'b0, ALU_OR, 1'b0, DEST_F, 1'b1);
            OP_XOR: if (ofs == 0) ctrl_word = cw(1'b0, 1'b0, ALU_XOR, 1'b0, DEST_F, 1'b1);
            OP_INC: if (ofs == 0) ctrl_word = cw(1'b0, 1'b0, ALU_INC, 1'b1, DEST_F, 1'b1);
            OP_DSUM: begin
                // Both temps take A+B, then F = TA+TB
                if (ofs == 0) ctrl_word = cw(1'b0, 1'b0, ALU_ADD, 1'b0, DEST_TA | DEST_TB, 1'b0);
                if (ofs == 1) ctrl_word = cw(1'b1, 1'b1, ALU_ADD, 1'b0, DEST_F, 1'b1);
            end
            OP_SUMSUB: begin
                if (ofs == 0) ctrl_word = cw(1'b0, 1'b0, ALU_ADD, 1'b0, DEST_TA, 1'b0);
                if (ofs == 1) ctrl_word = cw(1'b0, 1'b0, ALU_SUB, 1'b1, DEST_TB, 1'b0);
                if (ofs == 2) ctrl_word = cw(1'b1, 1'b1, ALU_XOR, 1'b0, DEST_F, 1'b1);
            end
            default: ;
        endcase
    end

endmodule

// ==== src/processor.sv ====
// Processor datapath

`timescale 1ns/1ps
`include "proc_defines.svh"

module processor
    import proc_types_pkg::*;
    import ucode_pkg::*;
(
    input  logic       system_clk,
    input  logic       arst_n,
    input  data_t      data_in_a,
    input  data_t      data_in_b,
    input  logic       eil,
    input  ctrl_word_t control_bits,
    output data_t      data_out,
    output status_t    status_bits
);

    logic      a_source;
    logic      b_source;
    alu_func_e alu_func;
    logic      cin;
    alu_dest_t alu_dest;

    data_t a_q, b_q, ta_q, tb_q, f_q;
    data_t alu_in_a, alu_in_b, alu_out;
    logic  alu_c4, alu_c8;
    logic  c4_q, c8_q, z_q;

    // Control word fields
    assign a_source = control_bits[CW_A_SRC];
    assign b_source = control_bits[CW_B_SRC];
    assign alu_func = alu_func_e'(control_bits[CW_FUNC_MSB:CW_FUNC_LSB]);
    assign cin      = control_bits[CW_CIN];
    assign alu_dest = control_bits[CW_DEST_MSB:CW_DEST_LSB];

    // Operand registers
    always_ff @(posedge system_clk or negedge arst_n) begin
        if (!arst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else if (eil) begin
            a_q <= data_in_a;
            b_q <= data_in_b;
        end
    end

    // Source muxes
    assign alu_in_a = a_source ? ta_q : a_q;
    assign alu_in_b = b_source ? tb_q : b_q;

    alu alu1 (
        .in_a     (alu_in_a),
        .in_b     (alu_in_b),
        .cin      (cin),
        .alu_func (alu_func),
        .out8     (alu_out),
        .c4       (alu_c4),
        .c8       (alu_c8)
    );

    // Temp registers and F, flags taken with every F write
    always_ff @(posedge system_clk or negedge arst_n) begin
        if (!arst_n) begin
            ta_q <= '0;
            tb_q <= '0;
            f_q  <= '0;
            c4_q <= 1'b0;
            c8_q <= 1'b0;
            z_q  <= 1'b0;
        end else begin
            if (alu_dest[0]) begin
                ta_q <= alu_out;
            end
            if (alu_dest[1]) begin
                tb_q <= alu_out;
            end
            if (alu_dest[2]) begin
                f_q  <= alu_out;
                c4_q <= alu_c4;
                c8_q <= alu_c8;
                // Zero of the value going into F
                z_q  <= (alu_out == '0);
            end
        end
    end

    assign data_out = f_q;

    assign status_bits[ST_C4] = c4_q;
    assign status_bits[ST_C8] = c8_q;
    assign status_bits[ST_Z]  = z_q;
    assign status_bits[ST_N]  = f_q[`DATA_W-1];

    // Operand load and microword execution are separate phases
    a_eil_no_write: assert property (
        @(posedge system_clk) disable iff (!arst_n)
        eil |-> (alu_dest == DEST_NONE)
    );

endmodule

// ==== src/alu.sv ====
// 8-bit ALU

`timescale 1ns/1ps
`include "proc_defines.svh"

module alu
    import proc_types_pkg::*;
    import ucode_pkg::*;
(
    input  data_t     in_a,
    input  data_t     in_b,
    input  logic      cin,
    input  alu_func_e alu_func,
    output data_t     out8,
    output logic      c4,
    output logic      c8
);

    localparam int NIB_W = `DATA_W / 2;

    data_t            b_op;
    logic [`DATA_W:0] sum;
    logic [NIB_W:0]   nib_sum;

    // B operand of the adder
    always_comb begin
        case (alu_func)
            ALU_SUB: b_op = ~in_b;
            ALU_INC: b_op = '0;
            default: b_op = in_b;
        endcase
    end

    assign sum     = {1'b0, in_a} + {1'b0, b_op} + cin;
    // Low nibble sum gives the half carry
    assign nib_sum = {1'b0, in_a[NIB_W-1:0]} + {1'b0, b_op[NIB_W-1:0]} + cin;

    always_comb begin
        c4   = 1'b0;
        c8   = 1'b0;
        case (alu_func)
            ALU_ADD, ALU_SUB, ALU_INC: begin
                out8 = sum[`DATA_W-1:0];
                c4   = nib_sum[NIB_W];
                c8   = sum[`DATA_W];
            end
            ALU_AND: out8 = in_a & in_b;
            ALU_OR:  out8 = in_a | in_b;
            ALU_XOR: out8 = in_a ^ in_b;
            // PASS_A and unused codes
            default: out8 = in_a;
        endcase
    end

endmodule

// ==== src/ucode_pkg.sv ====
// Microcode types and encodings

package ucode_pkg;

    `include "proc_defines.svh"

    typedef logic [`UADDR_W-1:0] uaddr_t;

    // Write enables, bit 0 TA, bit 1 TB, bit 2 F
    typedef logic [2:0] alu_dest_t;

    localparam alu_dest_t DEST_NONE = 3'b000;
    localparam alu_dest_t DEST_TA   = 3'b001;
    localparam alu_dest_t DEST_TB   = 3'b010;
    localparam alu_dest_t DEST_F    = 3'b100;

    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_AND    = 5'd2,
        ALU_OR     = 5'd3,
        ALU_XOR    = 5'd4,
        ALU_INC    = 5'd5,
        ALU_PASS_A = 5'd6
    } alu_func_e;

    typedef logic [11:0] ctrl_word_t;

    // Control word field positions
    localparam int CW_A_SRC    = 0;
    localparam int CW_B_SRC    = 1;
    localparam int CW_FUNC_LSB = 2;
    localparam int CW_FUNC_MSB = 6;
    localparam int CW_CIN      = 7;
    localparam int CW_DEST_LSB = 8;
    localparam int CW_DEST_MSB = 10;
    localparam int CW_LAST     = 11;

    // Opcodes 8 to 15 all decode as a move
    typedef enum logic [`OPC_W-1:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_XOR    = 4'd4,
        OP_INC    = 4'd5,
        OP_DSUM   = 4'd6,
        OP_SUMSUB = 4'd7,
        OP_MOVE   = 4'd8
    } opcode_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        EXEC = 2'd2,
        DONE = 2'd3
    } seq_state_e;

endpackage

// ==== src/proc_types_pkg.sv ====
// Datapath types

package proc_types_pkg;

    `include "proc_defines.svh"

    // One data byte
    typedef logic [`DATA_W-1:0] data_t;

    // Status word as seen by the host
    typedef logic [3:0] status_t;

    // Status bit positions
    localparam int ST_C4 = 0;
    localparam int ST_C8 = 1;
    localparam int ST_Z  = 2;
    localparam int ST_N  = 3;

endpackage

// ==== src/proc_defines.svh ====
// Processor size definitions

`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

// Data path and register width
`define DATA_W 8

// Host opcode width
`define OPC_W 4

// Microcode store address width
`define UADDR_W 6

// Microwords reserved for each opcode
// Base address of an opcode is opcode * UWORDS_PER_OP
`define UWORDS_PER_OP 4

`endif
